// ==== src/core_pkg.sv ====
package core_pkg;

    // datapath and register file sizes
    localparam int xlen       = 32;
    localparam int reg_addr_w = 5;
    localparam int nregs      = 32;

    // 3R and shift-immediate formats, matched on bits 31:15
    localparam logic [16:0] op_add_w  = {6'h00, 4'h0, 2'h1, 5'h00};
    localparam logic [16:0] op_sub_w  = {6'h00, 4'h0, 2'h1, 5'h02};
    localparam logic [16:0] op_slt    = {6'h00, 4'h0, 2'h1, 5'h04};
    localparam logic [16:0] op_sltu   = {6'h00, 4'h0, 2'h1, 5'h05};
    localparam logic [16:0] op_nor    = {6'h00, 4'h0, 2'h1, 5'h08};
    localparam logic [16:0] op_and    = {6'h00, 4'h0, 2'h1, 5'h09};
    localparam logic [16:0] op_or     = {6'h00, 4'h0, 2'h1, 5'h0a};
    localparam logic [16:0] op_xor    = {6'h00, 4'h0, 2'h1, 5'h0b};
    localparam logic [16:0] op_sll_w  = {6'h00, 4'h0, 2'h1, 5'h0e};
    localparam logic [16:0] op_srl_w  = {6'h00, 4'h0, 2'h1, 5'h0f};
    localparam logic [16:0] op_sra_w  = {6'h00, 4'h0, 2'h1, 5'h10};
    localparam logic [16:0] op_slli_w = {6'h00, 4'h1, 2'h0, 5'h01};
    localparam logic [16:0] op_srli_w = {6'h00, 4'h1, 2'h0, 5'h09};
    localparam logic [16:0] op_srai_w = {6'h00, 4'h1, 2'h0, 5'h11};

    // 2RI12 format, only bits 31:22 select the op
    localparam logic [9:0] op_slti   = {6'h00, 4'h8};
    localparam logic [9:0] op_sltui  = {6'h00, 4'h9};
    localparam logic [9:0] op_addi_w = {6'h00, 4'ha};
    localparam logic [9:0] op_andi   = {6'h00, 4'hd};
    localparam logic [9:0] op_ori    = {6'h00, 4'he};
    localparam logic [9:0] op_xori   = {6'h00, 4'hf};

    // 1RI20 format, bits 31:25
    localparam logic [6:0] op_lu12i_w = {6'h05, 1'b0};

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_slt,
        alu_sltu,
        alu_and,
        alu_nor,
        alu_or,
        alu_xor,
        alu_sll,
        alu_srl,
        alu_sra,
        alu_lui
    } alu_op_e;

    // how the second operand immediate is built
    typedef enum logic [1:0] {
        imm_ui5,
        imm_ui12,
        imm_si12,
        imm_si20
    } imm_kind_e;

    typedef struct packed {
        alu_op_e                 alu_op;
        logic [xlen-1:0]         src1;
        logic [xlen-1:0]         src2;
        logic [reg_addr_w-1:0]   rd;
        logic                    we;
    } exe_req_t;

    // one register write, also used for every forwarding source
    typedef struct packed {
        logic                    we;
        logic [reg_addr_w-1:0]   rd;
        logic [xlen-1:0]         data;
    } rf_write_t;

endpackage

// ==== src/regfile.sv ====
`timescale 1ns/100ps

module regfile (
    input  logic                               clk,
    input  logic                               resetn,
    input  logic [core_pkg::reg_addr_w-1:0]    raddr1,
    input  logic [core_pkg::reg_addr_w-1:0]    raddr2,
    output logic [core_pkg::xlen-1:0]          rdata1,
    output logic [core_pkg::xlen-1:0]          rdata2,
    input  core_pkg::rf_write_t                wr,
    input  logic                               wr_en
);
    logic [core_pkg::xlen-1:0] regs [core_pkg::nregs];

    always_ff @(posedge clk) begin
        if (!resetn) begin
            for (int i = 0; i < core_pkg::nregs; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && wr.we && wr.rd != '0) begin
            regs[wr.rd] <= wr.data;
        end
    end

    // r0 is hardwired to zero
    // no write bypass, the result stage forwards that value
    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

// ==== src/decode_stage.sv ====
`timescale 1ns/100ps

module decode_stage (
    input  logic                           clk,
    input  logic                           resetn,
    input  logic                           in_valid,
    input  logic [core_pkg::xlen-1:0]      in_inst,
    output logic                           in_allowin,
    input  logic                           exe_allowin,
    output logic                           exe_valid,
    output core_pkg::exe_req_t             exe_req,
    input  core_pkg::rf_write_t            exe_fwd,
    input  core_pkg::rf_write_t            res_fwd,
    input  logic                           retire_en,
    input  core_pkg::rf_write_t            retire
);
    logic                              valid_q;
    logic [core_pkg::xlen-1:0]         inst_q;
    logic [core_pkg::reg_addr_w-1:0]   rd;
    logic [core_pkg::reg_addr_w-1:0]   rj;
    logic [core_pkg::reg_addr_w-1:0]   rk;
    logic [4:0]                        ui5;
    logic [11:0]                       i12;
    logic [19:0]                       i20;
    core_pkg::alu_op_e                 alu_op;
    core_pkg::imm_kind_e               imm_kind;
    logic                              src2_is_imm;
    logic                              inst_ok;
    logic [core_pkg::xlen-1:0]         imm;
    logic [core_pkg::xlen-1:0]         rf_rdata1;
    logic [core_pkg::xlen-1:0]         rf_rdata2;
    logic [core_pkg::xlen-1:0]         rj_value;
    logic [core_pkg::xlen-1:0]         rk_value;

    // youngest in-flight writer wins, then the register file
    function automatic logic [core_pkg::xlen-1:0] fwd_pick(
        input logic [core_pkg::reg_addr_w-1:0] addr,
        input logic [core_pkg::xlen-1:0]       rf_data,
        input core_pkg::rf_write_t             exe,
        input core_pkg::rf_write_t             res
    );
        if (addr != '0 && exe.we && exe.rd == addr) begin
            return exe.data;
        end else if (addr != '0 && res.we && res.rd == addr) begin
            return res.data;
        end
        return rf_data;
    endfunction

    // no stall source in decode, so it only waits on execute
    assign in_allowin = !valid_q || exe_allowin;
    assign exe_valid  = valid_q;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            valid_q <= 1'b0;
        end else if (in_allowin) begin
            valid_q <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_allowin) begin
            inst_q <= in_inst;
        end
    end

    assign rd  = inst_q[4:0];
    assign rj  = inst_q[9:5];
    assign rk  = inst_q[14:10];
    assign ui5 = inst_q[14:10];
    assign i12 = inst_q[21:10];
    assign i20 = inst_q[24:5];

    // the three key spaces do not overlap, so order does not matter
    always_comb begin
        alu_op      = core_pkg::alu_add;
        imm_kind    = core_pkg::imm_si12;
        src2_is_imm = 1'b0;
        inst_ok     = 1'b1;
        case (inst_q[31:15])
            core_pkg::op_add_w:  alu_op = core_pkg::alu_add;
            core_pkg::op_sub_w:  alu_op = core_pkg::alu_sub;
            core_pkg::op_slt:    alu_op = core_pkg::alu_slt;
            core_pkg::op_sltu:   alu_op = core_pkg::alu_sltu;
            core_pkg::op_nor:    alu_op = core_pkg::alu_nor;
            core_pkg::op_and:    alu_op = core_pkg::alu_and;
            core_pkg::op_or:     alu_op = core_pkg::alu_or;
            core_pkg::op_xor:    alu_op = core_pkg::alu_xor;
            core_pkg::op_sll_w:  alu_op = core_pkg::alu_sll;
            core_pkg::op_srl_w:  alu_op = core_pkg::alu_srl;
            core_pkg::op_sra_w:  alu_op = core_pkg::alu_sra;
            core_pkg::op_slli_w,
            core_pkg::op_srli_w,
            core_pkg::op_srai_w: begin
                src2_is_imm = 1'b1;
                imm_kind    = core_pkg::imm_ui5;
                alu_op      = (inst_q[31:15] == core_pkg::op_slli_w) ? core_pkg::alu_sll :
                              (inst_q[31:15] == core_pkg::op_srli_w) ? core_pkg::alu_srl :
                                                                       core_pkg::alu_sra;
            end
            default: inst_ok = 1'b0;
        endcase
        case (inst_q[31:22])
            core_pkg::op_slti:   alu_op = core_pkg::alu_slt;
            core_pkg::op_sltui:  alu_op = core_pkg::alu_sltu;
            core_pkg::op_addi_w: alu_op = core_pkg::alu_add;
            core_pkg::op_andi:   alu_op = core_pkg::alu_and;
            core_pkg::op_ori:    alu_op = core_pkg::alu_or;
            core_pkg::op_xori:   alu_op = core_pkg::alu_xor;
            default: ;
        endcase
        if (inst_q[31:22] inside {core_pkg::op_slti, core_pkg::op_sltui, core_pkg::op_addi_w}) begin
            inst_ok     = 1'b1;
            src2_is_imm = 1'b1;
            imm_kind    = core_pkg::imm_si12;
        end
        if (inst_q[31:22] inside {core_pkg::op_andi, core_pkg::op_ori, core_pkg::op_xori}) begin
            inst_ok     = 1'b1;
            src2_is_imm = 1'b1;
            imm_kind    = core_pkg::imm_ui12;
        end
        if (inst_q[31:25] == core_pkg::op_lu12i_w) begin
            inst_ok     = 1'b1;
            src2_is_imm = 1'b1;
            imm_kind    = core_pkg::imm_si20;
            alu_op      = core_pkg::alu_lui;
        end
    end

    always_comb begin
        case (imm_kind)
            core_pkg::imm_ui5:  imm = {{(core_pkg::xlen-5){1'b0}}, ui5};
            core_pkg::imm_ui12: imm = {{(core_pkg::xlen-12){1'b0}}, i12};
            core_pkg::imm_si12: imm = {{(core_pkg::xlen-12){i12[11]}}, i12};
            default:            imm = {i20, 12'b0};
        endcase
    end

    regfile u_regfile (
        .clk    (clk),
        .resetn (resetn),
        .raddr1 (rj),
        .raddr2 (rk),
        .rdata1 (rf_rdata1),
        .rdata2 (rf_rdata2),
        .wr     (retire),
        .wr_en  (retire_en)
    );

    assign rj_value = fwd_pick(rj, rf_rdata1, exe_fwd, res_fwd);
    assign rk_value = fwd_pick(rk, rf_rdata2, exe_fwd, res_fwd);

    // unsupported words and writes to r0 travel on with we low
    always_comb begin
        exe_req.alu_op = alu_op;
        exe_req.src1   = rj_value;
        exe_req.src2   = src2_is_imm ? imm : rk_value;
        exe_req.rd     = rd;
        exe_req.we     = inst_ok && (rd != '0);
    end

endmodule

// ==== src/execute_stage.sv ====
`timescale 1ns/100ps

module execute_stage (
    input  logic                   clk,
    input  logic                   resetn,
    input  logic                   in_valid,
    input  core_pkg::exe_req_t     in_req,
    output logic                   in_allowin,
    output logic                   out_valid,
    input  logic                   out_allowin,
    output core_pkg::rf_write_t    out_res,
    output core_pkg::rf_write_t    fwd
);
    logic                          valid_q;
    core_pkg::exe_req_t            req_q;
    logic [core_pkg::xlen-1:0]     alu_res;
    logic [4:0]                    shamt;

    assign in_allowin = !valid_q || out_allowin;
    assign out_valid  = valid_q;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            valid_q <= 1'b0;
        end else if (in_allowin) begin
            valid_q <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_allowin) begin
            req_q <= in_req;
        end
    end

    // only the low 5 bits count for shifts
    assign shamt = req_q.src2[4:0];

    always_comb begin
        case (req_q.alu_op)
            core_pkg::alu_add:  alu_res = req_q.src1 + req_q.src2;
            core_pkg::alu_sub:  alu_res = req_q.src1 - req_q.src2;
            core_pkg::alu_slt:  alu_res = {31'b0, $signed(req_q.src1) < $signed(req_q.src2)};
            core_pkg::alu_sltu: alu_res = {31'b0, req_q.src1 < req_q.src2};
            core_pkg::alu_and:  alu_res = req_q.src1 & req_q.src2;
            core_pkg::alu_nor:  alu_res = ~(req_q.src1 | req_q.src2);
            core_pkg::alu_or:   alu_res = req_q.src1 | req_q.src2;
            core_pkg::alu_xor:  alu_res = req_q.src1 ^ req_q.src2;
            core_pkg::alu_sll:  alu_res = req_q.src1 << shamt;
            core_pkg::alu_srl:  alu_res = req_q.src1 >> shamt;
            core_pkg::alu_sra:  alu_res = $unsigned($signed(req_q.src1) >>> shamt);
            // lui already has the shifted immediate in src2
            core_pkg::alu_lui:  alu_res = req_q.src2;
            default:            alu_res = '0;
        endcase
    end

    always_comb begin
        out_res.we   = req_q.we;
        out_res.rd   = req_q.rd;
        out_res.data = alu_res;
    end

    // bubble must not match in decode
    always_comb begin
        fwd.we   = valid_q && req_q.we;
        fwd.rd   = req_q.rd;
        fwd.data = alu_res;
    end

endmodule

// ==== src/result_stage.sv ====
`timescale 1ns/100ps

module result_stage (
    input  logic                   clk,
    input  logic                   resetn,
    input  logic                   in_valid,
    input  core_pkg::rf_write_t    in_res,
    output logic                   in_allowin,
    output logic                   retire_valid,
    output core_pkg::rf_write_t    retire,
    input  logic                   retire_ready,
    output core_pkg::rf_write_t    fwd
);
    logic                  valid_q;
    core_pkg::rf_write_t   res_q;

    // item stays put until the retire handshake
    assign in_allowin   = !valid_q || retire_ready;
    assign retire_valid = valid_q;
    assign retire       = res_q;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            valid_q <= 1'b0;
        end else if (in_allowin) begin
            valid_q <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_allowin) begin
            res_q <= in_res;
        end
    end

    always_comb begin
        fwd.we   = valid_q && res_q.we;
        fwd.rd   = res_q.rd;
        fwd.data = res_q.data;
    end

endmodule

// ==== src/int_core.sv ====
`timescale 1ns/100ps

module int_core (
    input  logic                       clk,
    input  logic                       resetn,
    input  logic                       in_valid,
    input  logic [core_pkg::xlen-1:0]  in_inst,
    output logic                       in_allowin,
    output logic                       retire_valid,
    output core_pkg::rf_write_t        retire,
    input  logic                       retire_ready
);
    logic                  dec_valid;
    core_pkg::exe_req_t    dec_req;
    logic                  exe_allowin;
    logic                  exe_valid;
    core_pkg::rf_write_t   exe_res;
    core_pkg::rf_write_t   exe_fwd;
    logic                  res_allowin;
    core_pkg::rf_write_t   res_fwd;
    logic                  retire_en;

    // register file write happens on the retire handshake
    assign retire_en = retire_valid && retire_ready;

    decode_stage u_decode (
        .clk         (clk),
        .resetn      (resetn),
        .in_valid    (in_valid),
        .in_inst     (in_inst),
        .in_allowin  (in_allowin),
        .exe_allowin (exe_allowin),
        .exe_valid   (dec_valid),
        .exe_req     (dec_req),
        .exe_fwd     (exe_fwd),
        .res_fwd     (res_fwd),
        .retire_en   (retire_en),
        .retire      (retire)
    );

    execute_stage u_execute (
        .clk         (clk),
        .resetn      (resetn),
        .in_valid    (dec_valid),
        .in_req      (dec_req),
        .in_allowin  (exe_allowin),
        .out_valid   (exe_valid),
        .out_allowin (res_allowin),
        .out_res     (exe_res),
        .fwd         (exe_fwd)
    );

    result_stage u_result (
        .clk          (clk),
        .resetn       (resetn),
        .in_valid     (exe_valid),
        .in_res       (exe_res),
        .in_allowin   (res_allowin),
        .retire_valid (retire_valid),
        .retire       (retire),
        .retire_ready (retire_ready),
        .fwd          (res_fwd)
    );

endmodule

// ==== verification/int_core_props.sv ====
`timescale 1ns/100ps

module int_core_props (
    input  logic                   clk,
    input  logic                   resetn,
    input  logic                   in_allowin,
    input  logic                   retire_valid,
    input  core_pkg::rf_write_t    retire,
    input  logic                   retire_ready
);
    // pipeline comes out of reset empty
    reset_empty: assert property (@(posedge clk) !resetn |=> !retire_valid)
        else $error("retire_valid high in the cycle after reset");

    // stalled retire port holds its item
    retire_hold: assert property (@(posedge clk) disable iff (!resetn)
        (retire_valid && !retire_ready) |=> (retire_valid && $stable(retire)))
        else $error("retire output changed while stalled");

    // three cycles of ready leave room at the front
    drain_allowin: assert property (@(posedge clk) disable iff (!resetn)
        (retire_ready && $past(retire_ready) && $past(retire_ready, 2)) |-> in_allowin)
        else $error("in_allowin low after three ready cycles");

endmodule

bind int_core int_core_props u_props (
    .clk          (clk),
    .resetn       (resetn),
    .in_allowin   (in_allowin),
    .retire_valid (retire_valid),
    .retire       (retire),
    .retire_ready (retire_ready)
);

// ==== verification/tb_int_core.sv ====
`timescale 1ns/100ps

module tb_int_core;
    localparam int num_insts  = 2000;
    localparam int clk_period = 10;

    // instruction kinds for the generator and the model
    localparam int k_add = 0, k_sub = 1, k_slt = 2, k_sltu = 3,
                   k_and = 4, k_or = 5, k_nor = 6, k_xor = 7,
                   k_sll = 8, k_srl = 9, k_sra = 10,
                   k_slli = 11, k_srli = 12, k_srai = 13,
                   k_addi = 14, k_slti = 15, k_sltui = 16,
                   k_andi = 17, k_ori = 18, k_xori = 19,
                   k_lu12i = 20, k_bad = 21;

    logic                  clk = 1'b0;
    logic                  resetn;
    logic                  in_valid;
    logic [31:0]           in_inst;
    logic                  in_allowin;
    logic                  retire_valid;
    core_pkg::rf_write_t   retire;
    logic                  retire_ready;

    logic [31:0]           model_regs [32];
    core_pkg::rf_write_t   expected_q [$];
    bit                    kept_q [$];
    int                    retired = 0;

    int_core UUT (
        .clk          (clk),
        .resetn       (resetn),
        .in_valid     (in_valid),
        .in_inst      (in_inst),
        .in_allowin   (in_allowin),
        .retire_valid (retire_valid),
        .retire       (retire),
        .retire_ready (retire_ready)
    );

    always #(clk_period / 2) clk = ~clk;

    task automatic stop_with_fail(input string why);
        $display("%s", why);
        $display("STATUS: FAIL");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic value_error(input string name, input logic [31:0] got,
                               input logic [31:0] want);
        stop_with_fail($sformatf("[ERROR] %0t ns: %s is %h, expected %h",
                                 $time, name, got, want));
    endtask

    // registers 0..7 only, so dependences stay close together
    function automatic logic [31:0] make_inst(input int kind);
        logic [4:0]  rd;
        logic [4:0]  rj;
        logic [4:0]  rk;
        logic [19:0] imm;
        logic [31:0] word;
        rd  = 5'($urandom_range(7));
        rj  = 5'($urandom_range(7));
        rk  = 5'($urandom_range(7));
        imm = 20'($urandom);
        case (kind)
            k_add:   word = {core_pkg::op_add_w, rk, rj, rd};
            k_sub:   word = {core_pkg::op_sub_w, rk, rj, rd};
            k_slt:   word = {core_pkg::op_slt, rk, rj, rd};
            k_sltu:  word = {core_pkg::op_sltu, rk, rj, rd};
            k_and:   word = {core_pkg::op_and, rk, rj, rd};
            k_or:    word = {core_pkg::op_or, rk, rj, rd};
            k_nor:   word = {core_pkg::op_nor, rk, rj, rd};
            k_xor:   word = {core_pkg::op_xor, rk, rj, rd};
            k_sll:   word = {core_pkg::op_sll_w, rk, rj, rd};
            k_srl:   word = {core_pkg::op_srl_w, rk, rj, rd};
            k_sra:   word = {core_pkg::op_sra_w, rk, rj, rd};
            k_slli:  word = {core_pkg::op_slli_w, imm[4:0], rj, rd};
            k_srli:  word = {core_pkg::op_srli_w, imm[4:0], rj, rd};
            k_srai:  word = {core_pkg::op_srai_w, imm[4:0], rj, rd};
            k_addi:  word = {core_pkg::op_addi_w, imm[11:0], rj, rd};
            k_slti:  word = {core_pkg::op_slti, imm[11:0], rj, rd};
            k_sltui: word = {core_pkg::op_sltui, imm[11:0], rj, rd};
            k_andi:  word = {core_pkg::op_andi, imm[11:0], rj, rd};
            k_ori:   word = {core_pkg::op_ori, imm[11:0], rj, rd};
            k_xori:  word = {core_pkg::op_xori, imm[11:0], rj, rd};
            k_lu12i: word = {core_pkg::op_lu12i_w, imm, rd};
            default: begin
                // major opcodes 6..63 hold no kept instruction
                word        = $urandom;
                word[31:26] = 6'($urandom_range(63, 6));
            end
        endcase
        return word;
    endfunction

    function automatic core_pkg::rf_write_t model_exec(input int kind, input logic [31:0] w);
        core_pkg::rf_write_t res;
        logic [31:0]         a;
        logic [31:0]         b;
        logic [31:0]         si12;
        logic [31:0]         ui12;
        a        = model_regs[w[9:5]];
        b        = model_regs[w[14:10]];
        si12     = {{20{w[21]}}, w[21:10]};
        ui12     = {20'b0, w[21:10]};
        res.rd   = w[4:0];
        res.we   = (kind != k_bad) && (w[4:0] != 5'd0);
        res.data = '0;
        case (kind)
            k_add:   res.data = a + b;
            k_sub:   res.data = a - b;
            k_slt:   res.data = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            k_sltu:  res.data = (a < b) ? 32'd1 : 32'd0;
            k_and:   res.data = a & b;
            k_or:    res.data = a | b;
            k_nor:   res.data = ~(a | b);
            k_xor:   res.data = a ^ b;
            k_sll:   res.data = a << b[4:0];
            k_srl:   res.data = a >> b[4:0];
            k_sra:   res.data = $unsigned($signed(a) >>> b[4:0]);
            k_slli:  res.data = a << w[14:10];
            k_srli:  res.data = a >> w[14:10];
            k_srai:  res.data = $unsigned($signed(a) >>> w[14:10]);
            k_addi:  res.data = a + si12;
            k_slti:  res.data = ($signed(a) < $signed(si12)) ? 32'd1 : 32'd0;
            k_sltui: res.data = (a < si12) ? 32'd1 : 32'd0;
            k_andi:  res.data = a & ui12;
            k_ori:   res.data = a | ui12;
            k_xori:  res.data = a ^ ui12;
            k_lu12i: res.data = {w[24:5], 12'b0};
            default: res.data = '0;
        endcase
        return res;
    endfunction

    // retire handshake pops the model queue, in program order
    always @(posedge clk) begin : retire_check
        core_pkg::rf_write_t want;
        bit                  kept;
        if (resetn && retire_valid && retire_ready) begin
            assert (expected_q.size() != 0)
                else stop_with_fail("an instruction retired that was never issued");
            want = expected_q.pop_front();
            kept = kept_q.pop_front();
            assert (retire.rd == want.rd)
                else value_error("retire.rd", 32'(retire.rd), 32'(want.rd));
            assert (retire.we == want.we)
                else value_error("retire.we", 32'(retire.we), 32'(want.we));
            if (kept) begin
                assert (retire.data == want.data)
                    else value_error("retire.data", retire.data, want.data);
            end
            retired++;
        end
    end

    initial begin : watchdog
        #(num_insts * 10 * clk_period);
        stop_with_fail("timeout: retirement stalled before all instructions retired");
    end

    initial begin : stimulus
        int                  kind;
        int                  issued;
        bit                  have_word;
        core_pkg::rf_write_t want;
        for (int i = 0; i < 32; i++) begin
            model_regs[i] = '0;
        end
        void'($urandom(32'h0988_17cc));
        resetn       = 1'b0;
        in_valid     = 1'b0;
        in_inst      = '0;
        retire_ready = 1'b0;
        issued       = 0;
        have_word    = 1'b0;
        kind         = k_bad;
        repeat (5) @(posedge clk);
        #1;
        resetn = 1'b1;
        while (issued < num_insts) begin
            // a word stays on the input until it is taken
            if (!have_word) begin
                kind      = ($urandom_range(99) < 5) ? k_bad : int'($urandom_range(20));
                in_inst   = make_inst(kind);
                have_word = 1'b1;
            end
            in_valid     = ($urandom_range(99) >= 30);
            retire_ready = ($urandom_range(99) >= 30);
            @(posedge clk);
            if (in_valid && in_allowin) begin
                want = model_exec(kind, in_inst);
                if (want.we) begin
                    model_regs[want.rd] = want.data;
                end
                expected_q.push_back(want);
                kept_q.push_back(kind != k_bad);
                issued++;
                have_word = 1'b0;
            end
            #1;
        end
        in_valid = 1'b0;
        while (retired < num_insts) begin
            retire_ready = ($urandom_range(99) >= 30);
            @(posedge clk);
            #1;
        end
        // nothing more may come out
        retire_ready = 1'b1;
        repeat (4) @(posedge clk);
        #1;
        if (expected_q.size() == 0 && retired == num_insts && !retire_valid) begin
            $display("STATUS: PASS");
            $finish;
        end else begin
            stop_with_fail("instructions left over or retired twice at end of run");
        end
    end

endmodule

// ==== project.f ====
src/core_pkg.sv
src/regfile.sv
src/decode_stage.sv
src/execute_stage.sv
src/result_stage.sv
src/int_core.sv
verification/int_core_props.sv
verification/tb_int_core.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert -f project.f --top-module tb_int_core \
    --Mdir obj_dir -o tb_int_core_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/tb_int_core_sim > "$log" 2>&1
sim_status=$?
cat "$log"

if grep -q "STATUS: FAIL" "$log"; then
    echo "simulation reported a failure"
    exit 1
fi
if [ $sim_status -ne 0 ] || ! grep -q "STATUS: PASS" "$log"; then
    echo "simulation ended without passing"
    exit 1
fi
exit 0
